/* common/avr_pkg.sv */
`default_nettype none

package avr_pkg;

    // ----------------------------------------------------------
    // Widths with a meaning
    // ----------------------------------------------------------
    typedef logic [7:0]  byte_t;      // Register and I/O data
    typedef logic [15:0] pc_t;        // Program word address
    typedef logic [15:0] insn_t;      // One instruction word
    typedef logic [4:0]  reg_idx_t;   // R0..R31
    typedef logic [5:0]  io_addr_t;   // OUT address space
    typedef logic [7:0]  sreg_t;      // Status register

    localparam int NUM_REGS     = 32;
    localparam int IMM_REG_BASE = 16;   // Immediate forms reach R16..R31 only
    localparam pc_t RESET_PC    = 16'h0000;

    // SREG bit positions
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;
    localparam int FLAG_S = 4;
    localparam int FLAG_H = 5;
    localparam int FLAG_T = 6;
    localparam int FLAG_I = 7;

    // ----------------------------------------------------------
    // Opcode groups, selected by ir[15:12]
    // ----------------------------------------------------------
    localparam logic [3:0] OPG_REG0   = 4'h0;  // CPC, SBC, ADD
    localparam logic [3:0] OPG_REG1   = 4'h1;  // CP, SUB, ADC
    localparam logic [3:0] OPG_REG2   = 4'h2;  // AND, EOR, OR, MOV
    localparam logic [3:0] OPG_CPI    = 4'h3;
    localparam logic [3:0] OPG_SBCI   = 4'h4;
    localparam logic [3:0] OPG_SUBI   = 4'h5;
    localparam logic [3:0] OPG_ORI    = 4'h6;
    localparam logic [3:0] OPG_ANDI   = 4'h7;
    localparam logic [3:0] OPG_SINGLE = 4'h9;  // One-operand group
    localparam logic [3:0] OPG_IO     = 4'hB;  // OUT when ir[11] set
    localparam logic [3:0] OPG_RJMP   = 4'hC;
    localparam logic [3:0] OPG_LDI    = 4'hE;
    localparam logic [3:0] OPG_BRANCH = 4'hF;  // BRBS/BRBC when ir[11] clear

    // ----------------------------------------------------------
    // Micro-operation
    // ----------------------------------------------------------
    typedef enum logic [4:0] {
        PASS,
        ADD,
        ADC,
        SUB,
        SBC,
        AND,
        EOR,
        OR,
        COM,
        NEG,
        SWAP,
        INC,
        DEC,
        ASR,
        LSR,
        ROR,
        NONE
    } alu_op_e;

    typedef struct packed {
        alu_op_e  op;
        byte_t    operand_a;   // Rd
        byte_t    operand_b;   // Rr or K
        reg_idx_t dest;
        logic     reg_we;
        logic     sreg_we;
        logic     keep_z;      // Z only holds or clears
    } uop_t;

endpackage

`default_nettype wire

/* verilog/avr_regfile.sv */
`default_nettype none

module avr_regfile
    import avr_pkg::*;
(
    input  wire            clock,
    input  wire            rst_n_i,
    input  wire reg_idx_t  rd_addr_a_i,
    input  wire reg_idx_t  rd_addr_b_i,
    input  wire            wr_en_i,
    input  wire reg_idx_t  wr_addr_i,
    input  wire byte_t     wr_data_i,
    output byte_t          rd_data_a_o,
    output byte_t          rd_data_b_o
);

    byte_t regs_q [NUM_REGS];

    // Write lands at the edge, so the next instruction reads it
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= 8'h00;
            end
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Combinational read ports
    assign rd_data_a_o = regs_q[rd_addr_a_i];
    assign rd_data_b_o = regs_q[rd_addr_b_i];

    // Decoder and ALU stay quiet while the core is held in reset
    a_no_write_in_reset: assert property (@(posedge clock)
        !rst_n_i |-> !wr_en_i)
        else $error("register write during reset");

endmodule

`default_nettype wire

/* decode/avr_decode.sv */
`default_nettype none

module avr_decode
    import avr_pkg::*;
(
    input  wire           clock,
    input  wire           rst_n_i,
    input  wire insn_t    ir_i,
    input  wire byte_t    rd_data_a_i,
    input  wire byte_t    rd_data_b_i,
    input  wire sreg_t    sreg_i,
    output pc_t           pc_o,
    output reg_idx_t      rd_addr_a_o,
    output reg_idx_t      rd_addr_b_o,
    output uop_t          uop_o,
    output logic          io_we_o,
    output io_addr_t      io_addr_o,
    output byte_t         io_data_o
);

    pc_t      pc_q;
    pc_t      pc_next;
    pc_t      rjmp_off;
    pc_t      br_off;
    reg_idx_t rd_f;
    reg_idx_t rr_f;
    reg_idx_t rdi_f;
    byte_t    k_f;
    logic     imm_form;
    logic     is_out;
    logic     br_taken;
    uop_t     uop;
    logic     io_we_q;
    io_addr_t io_addr_q;
    byte_t    io_data_q;

    // ----------------------------------------------------------
    // Opcode fields
    // ----------------------------------------------------------
    assign rd_f     = ir_i[8:4];
    assign rr_f     = {ir_i[9], ir_i[3:0]};
    assign rdi_f    = reg_idx_t'(IMM_REG_BASE) + reg_idx_t'(ir_i[7:4]);
    assign k_f      = {ir_i[11:8], ir_i[3:0]};
    assign rjmp_off = {{4{ir_i[11]}}, ir_i[11:0]};
    assign br_off   = {{9{ir_i[9]}}, ir_i[9:3]};   // Signed 7-bit

    assign imm_form = ir_i[15:12] inside {OPG_CPI, OPG_SBCI, OPG_SUBI, OPG_ORI,
                                          OPG_ANDI, OPG_LDI};
    assign is_out   = (ir_i[15:12] == OPG_IO) && ir_i[11];
    // BRBS taken on a set bit, BRBC (ir[10]) on a clear one
    assign br_taken = (ir_i[15:12] == OPG_BRANCH) && !ir_i[11]
                      && (sreg_i[ir_i[2:0]] != ir_i[10]);

    assign rd_addr_a_o = imm_form ? rdi_f : rd_f;
    assign rd_addr_b_o = rr_f;

    always_comb begin
        uop.op        = NONE;
        uop.operand_a = rd_data_a_i;
        uop.operand_b = rd_data_b_i;
        uop.dest      = rd_f;
        uop.reg_we    = 1'b0;
        uop.sreg_we   = 1'b0;
        uop.keep_z    = 1'b0;
        case (ir_i[15:12])
            OPG_REG0, OPG_REG1, OPG_REG2: begin
                case (ir_i[13:10])
                    4'b0001, 4'b0010: uop.op = SBC;   // CPC, SBC
                    4'b0011:          uop.op = ADD;
                    4'b0101, 4'b0110: uop.op = SUB;   // CP, SUB
                    4'b0111:          uop.op = ADC;
                    4'b1000:          uop.op = AND;
                    4'b1001:          uop.op = EOR;
                    4'b1010:          uop.op = OR;
                    4'b1011:          uop.op = PASS;  // MOV
                    default:          uop.op = NONE;  // MOVW, MUL, CPSE
                endcase
                uop.reg_we  = (uop.op != NONE) && !(ir_i[13:10] inside {4'b0001, 4'b0101});
                uop.sreg_we = (uop.op != NONE) && (uop.op != PASS);
                uop.keep_z  = (uop.op == SBC);
            end
            OPG_CPI, OPG_SBCI, OPG_SUBI, OPG_ORI, OPG_ANDI: begin
                case (ir_i[15:12])
                    OPG_CPI, OPG_SUBI: uop.op = SUB;
                    OPG_SBCI:          uop.op = SBC;
                    OPG_ORI:           uop.op = OR;
                    default:           uop.op = AND;
                endcase
                uop.operand_b = k_f;
                uop.dest      = rdi_f;
                uop.reg_we    = (ir_i[15:12] != OPG_CPI);   // CPI only sets flags
                uop.sreg_we   = 1'b1;
                uop.keep_z    = (ir_i[15:12] == OPG_SBCI);
            end
            OPG_LDI: begin
                uop.op        = PASS;
                uop.operand_b = k_f;
                uop.dest      = rdi_f;
                uop.reg_we    = 1'b1;
            end
            OPG_SINGLE: begin
                if (ir_i[11:9] == 3'b010) begin
                    case (ir_i[3:0])
                        4'h0:    uop.op = COM;
                        4'h1:    uop.op = NEG;
                        4'h2:    uop.op = SWAP;
                        4'h3:    uop.op = INC;
                        4'h5:    uop.op = ASR;
                        4'h6:    uop.op = LSR;
                        4'h7:    uop.op = ROR;
                        4'hA:    uop.op = DEC;
                        default: uop.op = NONE;
                    endcase
                    uop.reg_we  = (uop.op != NONE);
                    uop.sreg_we = (uop.op != NONE);  // SWAP flags held in the ALU
                end
            end
            default: ;  // NOP, jumps, OUT and dropped codes
        endcase
    end

    // ----------------------------------------------------------
    // Program counter and OUT port
    // ----------------------------------------------------------
    always_comb begin
        pc_next = pc_q + 16'd1;
        if (ir_i[15:12] == OPG_RJMP) begin
            pc_next = pc_next + rjmp_off;
        end else if (br_taken) begin
            pc_next = pc_next + br_off;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_PC;
            io_we_q <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            io_we_q <= is_out;  // One-cycle strobe per OUT
        end
    end

    always_ff @(posedge clock) begin
        if (is_out) begin
            io_addr_q <= {ir_i[10:9], ir_i[3:0]};
            io_data_q <= rd_data_a_i;
        end
    end

    assign pc_o      = pc_q;
    assign uop_o     = uop;
    assign io_we_o   = io_we_q;
    assign io_addr_o = io_addr_q;
    assign io_data_o = io_data_q;

    // Back-to-back strobes only for back-to-back OUTs (1011 1AAr rrrr AAAA)
    a_out_strobe: assert property (@(posedge clock) disable iff (!rst_n_i)
        io_we_o |=> (!io_we_o || $past(ir_i[15:11] == 5'b10111)))
        else $error("io_we_o held without a second OUT");

endmodule

`default_nettype wire

/* alu/avr_alu.sv */
`default_nettype none

module avr_alu
    import avr_pkg::*;
(
    input  wire          clock,
    input  wire          rst_n_i,
    input  wire uop_t    uop_i,
    output logic         wr_en_o,
    output reg_idx_t     wr_addr_o,
    output byte_t        wr_data_o,
    output sreg_t        sreg_o
);

    sreg_t sreg_q;
    sreg_t flags;
    byte_t op_a;
    byte_t op_b;
    byte_t result;
    byte_t add_x;
    byte_t add_y;
    byte_t add_r;
    logic  add_cin;
    logic  add_sub;
    logic  [8:0] add_sum;
    logic  add_h;
    logic  add_v;
    logic  shift_msb;

    assign op_a = uop_i.operand_a;
    assign op_b = uop_i.operand_b;

    // ----------------------------------------------------------
    // Shared adder for ADD/ADC/SUB/SBC/NEG
    // ----------------------------------------------------------
    always_comb begin
        add_x   = op_a;
        add_y   = op_b;
        add_cin = 1'b0;
        add_sub = uop_i.op inside {SUB, SBC, NEG};
        if (uop_i.op inside {ADC, SBC}) begin
            add_cin = sreg_q[FLAG_C];
        end
        if (uop_i.op == NEG) begin   // 0 - Rd
            add_x = 8'h00;
            add_y = op_a;
        end
    end

    assign add_sum = add_sub ? ({1'b0, add_x} - {1'b0, add_y} - {8'd0, add_cin})
                             : ({1'b0, add_x} + {1'b0, add_y} + {8'd0, add_cin});
    assign add_r   = add_sum[7:0];
    // Bit 8 is carry for add and borrow for subtract
    assign add_h = add_sub ? ((~add_x[3] & add_y[3]) | (add_y[3] & add_r[3]) | (add_r[3] & ~add_x[3]))
                           : ((add_x[3] & add_y[3]) | (add_y[3] & ~add_r[3]) | (~add_r[3] & add_x[3]));
    assign add_v = add_sub ? ((add_x[7] & ~add_y[7] & ~add_r[7]) | (~add_x[7] & add_y[7] & add_r[7]))
                           : ((add_x[7] & add_y[7] & ~add_r[7]) | (~add_x[7] & ~add_y[7] & add_r[7]));

    assign shift_msb = (uop_i.op == ASR) ? op_a[7] :
                       (uop_i.op == ROR) ? sreg_q[FLAG_C] : 1'b0;

    // ----------------------------------------------------------
    // Result and new flags
    // ----------------------------------------------------------
    always_comb begin
        result = op_b;   // PASS for LDI and MOV
        flags  = sreg_q;
        case (uop_i.op)
            ADD, ADC, SUB, SBC, NEG: begin
                result        = add_r;
                flags[FLAG_H] = add_h;
                flags[FLAG_V] = add_v;
                flags[FLAG_C] = add_sum[8];
            end
            AND, EOR, OR: begin
                result        = (uop_i.op == AND) ? (op_a & op_b) :
                                (uop_i.op == EOR) ? (op_a ^ op_b) : (op_a | op_b);
                flags[FLAG_V] = 1'b0;
            end
            COM: begin
                result        = ~op_a;
                flags[FLAG_V] = 1'b0;
                flags[FLAG_C] = 1'b1;
            end
            INC: begin
                result        = op_a + 8'd1;
                flags[FLAG_V] = (result == 8'h80);
            end
            DEC: begin
                result        = op_a - 8'd1;
                flags[FLAG_V] = (result == 8'h7F);
            end
            ASR, LSR, ROR: begin
                result        = {shift_msb, op_a[7:1]};
                flags[FLAG_C] = op_a[0];
                flags[FLAG_V] = result[7] ^ op_a[0];   // N xor C
            end
            SWAP: result = {op_a[3:0], op_a[7:4]};
            default: ;
        endcase
        if (!(uop_i.op inside {PASS, SWAP, NONE})) begin
            flags[FLAG_N] = result[7];
            flags[FLAG_Z] = (result == 8'h00) && (!uop_i.keep_z || sreg_q[FLAG_Z]);
            flags[FLAG_S] = result[7] ^ flags[FLAG_V];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            sreg_q <= 8'h00;
        end else if (uop_i.sreg_we) begin
            sreg_q <= flags;
        end
    end

    assign wr_en_o   = uop_i.reg_we;
    assign wr_addr_o = uop_i.dest;
    assign wr_data_o = result;
    assign sreg_o    = sreg_q;

    // No kept instruction touches I or T
    a_i_t_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
        $stable({sreg_q[FLAG_I], sreg_q[FLAG_T]}))
        else $error("SREG I/T changed");

endmodule

`default_nettype wire

/* verilog/avr_core.sv */
`default_nettype none

module avr_core
    import avr_pkg::*;
(
    input  wire            clock,
    input  wire            rst_n_i,
    input  wire insn_t     ir_i,
    output wire pc_t       pc_o,
    output wire            io_we_o,
    output wire io_addr_t  io_addr_o,
    output wire byte_t     io_data_o
);

    reg_idx_t rd_addr_a;
    reg_idx_t rd_addr_b;
    byte_t    rd_data_a;
    byte_t    rd_data_b;
    uop_t     uop;          // Decoder to ALU
    logic     wr_en;
    reg_idx_t wr_addr;
    byte_t    wr_data;
    sreg_t    sreg;         // Flags back for branches

    avr_decode u_decode (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .ir_i        (ir_i),
        .rd_data_a_i (rd_data_a),
        .rd_data_b_i (rd_data_b),
        .sreg_i      (sreg),
        .pc_o        (pc_o),
        .rd_addr_a_o (rd_addr_a),
        .rd_addr_b_o (rd_addr_b),
        .uop_o       (uop),
        .io_we_o     (io_we_o),
        .io_addr_o   (io_addr_o),
        .io_data_o   (io_data_o)
    );

    avr_regfile u_regfile (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b)
    );

    avr_alu u_alu (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .uop_i     (uop),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data),
        .sreg_o    (sreg)
    );

endmodule

`default_nettype wire

/* test/avr_model.svh */
`ifndef AVR_MODEL_SVH
`define AVR_MODEL_SVH

// ------------------------------------------------------------
// Instruction-set model of the reduced core
// ------------------------------------------------------------
byte_t    m_regs [NUM_REGS];
sreg_t    m_sreg;
pc_t      m_pc;
logic     m_out_we;     // Strobe expected in the next cycle
io_addr_t m_out_addr;
byte_t    m_out_data;

// ir[15:10] of CPC, SBC, ADD, CP, SUB, ADC, AND, EOR, OR, MOV
localparam logic [5:0] REG_OPS [10] = '{6'b000001, 6'b000010, 6'b000011, 6'b000101,
    6'b000110, 6'b000111, 6'b001000, 6'b001001, 6'b001010, 6'b001011};
// COM, NEG, SWAP, INC, ASR, LSR, ROR, DEC
localparam logic [3:0] SINGLE_OPS [8] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h5, 4'h6, 4'h7, 4'hA};

task automatic model_reset();
    for (int i = 0; i < NUM_REGS; i++) begin
        m_regs[i] = 8'h00;
    end
    m_sreg   = 8'h00;
    m_pc     = RESET_PC;
    m_out_we = 1'b0;
endtask

// N, Z and S from a result once V is known
task automatic set_nzs(input byte_t r, input logic chain_z);
    m_sreg[FLAG_N] = r[7];
    m_sreg[FLAG_Z] = (r == 8'h00) && (!chain_z || m_sreg[FLAG_Z]);
    m_sreg[FLAG_S] = r[7] ^ m_sreg[FLAG_V];
endtask

// Add or subtract with carry, half carry and overflow as the AVR defines them
task automatic arith(input reg_idx_t dst, input byte_t a, input byte_t b, input logic cin,
                     input logic sub, input logic chain_z, input logic store);
    int    full;
    int    low;
    byte_t r;
    full = sub ? (int'(a) - int'(b) - int'(cin)) : (int'(a) + int'(b) + int'(cin));
    low  = sub ? (int'(a[3:0]) - int'(b[3:0]) - int'(cin))
               : (int'(a[3:0]) + int'(b[3:0]) + int'(cin));
    r = full[7:0];
    m_sreg[FLAG_C] = (full < 0) || (full > 255);   // Borrow or carry out of bit 7
    m_sreg[FLAG_H] = (low < 0) || (low > 15);
    m_sreg[FLAG_V] = (sub ? (a[7] != b[7]) : (a[7] == b[7])) && (r[7] != a[7]);
    set_nzs(r, chain_z);
    if (store) begin
        m_regs[dst] = r;
    end
endtask

task automatic put_result(input reg_idx_t dst, input byte_t r, input logic v);
    m_sreg[FLAG_V] = v;
    set_nzs(r, 1'b0);
    m_regs[dst] = r;
endtask

task automatic model_step(input insn_t w);
    reg_idx_t d;
    reg_idx_t r;
    reg_idx_t dh;
    byte_t    k;
    byte_t    a;
    logic     c;
    d  = w[8:4];
    r  = {w[9], w[3:0]};
    dh = {1'b1, w[7:4]};   // R16..R31
    k  = {w[11:8], w[3:0]};
    a  = m_regs[d];
    c  = m_sreg[FLAG_C];
    m_out_we = 1'b0;
    casez (w)
        16'b0000_01??_????_????: arith(d, a, m_regs[r], c, 1'b1, 1'b1, 1'b0);     // CPC
        16'b0000_10??_????_????: arith(d, a, m_regs[r], c, 1'b1, 1'b1, 1'b1);     // SBC
        16'b0000_11??_????_????: arith(d, a, m_regs[r], 1'b0, 1'b0, 1'b0, 1'b1);  // ADD
        16'b0001_01??_????_????: arith(d, a, m_regs[r], 1'b0, 1'b1, 1'b0, 1'b0);  // CP
        16'b0001_10??_????_????: arith(d, a, m_regs[r], 1'b0, 1'b1, 1'b0, 1'b1);  // SUB
        16'b0001_11??_????_????: arith(d, a, m_regs[r], c, 1'b0, 1'b0, 1'b1);     // ADC
        16'b0010_00??_????_????: put_result(d, a & m_regs[r], 1'b0);
        16'b0010_01??_????_????: put_result(d, a ^ m_regs[r], 1'b0);
        16'b0010_10??_????_????: put_result(d, a | m_regs[r], 1'b0);
        16'b0010_11??_????_????: m_regs[d] = m_regs[r];                           // MOV
        16'b0011_????_????_????: arith(dh, m_regs[dh], k, 1'b0, 1'b1, 1'b0, 1'b0); // CPI
        16'b0100_????_????_????: arith(dh, m_regs[dh], k, c, 1'b1, 1'b1, 1'b1);    // SBCI
        16'b0101_????_????_????: arith(dh, m_regs[dh], k, 1'b0, 1'b1, 1'b0, 1'b1); // SUBI
        16'b0110_????_????_????: put_result(dh, m_regs[dh] | k, 1'b0);
        16'b0111_????_????_????: put_result(dh, m_regs[dh] & k, 1'b0);
        16'b1110_????_????_????: m_regs[dh] = k;                                  // LDI
        16'b1001_010?_????_0000: begin   // COM
            m_sreg[FLAG_C] = 1'b1;
            put_result(d, ~a, 1'b0);
        end
        16'b1001_010?_????_0001: arith(d, 8'h00, a, 1'b0, 1'b1, 1'b0, 1'b1);      // NEG
        16'b1001_010?_????_0010: m_regs[d] = {a[3:0], a[7:4]};
        16'b1001_010?_????_0011: put_result(d, a + 8'd1, a == 8'h7F);             // INC
        16'b1001_010?_????_1010: put_result(d, a - 8'd1, a == 8'h80);             // DEC
        16'b1001_010?_????_0101, 16'b1001_010?_????_011?: begin   // ASR, LSR, ROR
            m_sreg[FLAG_C] = a[0];
            put_result(d, {(w[1:0] == 2'b01) ? a[7] : (w[0] & c), a[7:1]},
                       ((w[1:0] == 2'b01) ? a[7] : (w[0] & c)) ^ a[0]);
        end
        16'b1100_????_????_????: m_pc = m_pc + {{4{w[11]}}, w[11:0]};           // RJMP
        16'b1111_0???_????_????: begin   // BRBS, BRBC
            // BRBC waits for a clear bit, BRBS for a set one
            if (w[10] ? !m_sreg[w[2:0]] : m_sreg[w[2:0]]) begin
                m_pc = m_pc + {{9{w[9]}}, w[9:3]};
            end
        end
        16'b1011_1???_????_????: begin   // OUT
            m_out_we   = 1'b1;
            m_out_addr = {w[10:9], w[3:0]};
            m_out_data = a;
        end
        default: ;   // NOP and dropped codes
    endcase
    m_pc = m_pc + 16'd1;
endtask

// Mostly kept instructions, about one in five an OUT
function automatic insn_t random_insn();
    insn_t       w;
    int unsigned pick;
    w    = insn_t'($urandom);
    pick = $urandom_range(99);
    if (pick < 20) begin
        w[15:11] = 5'b10111;
    end else if (pick < 25) begin
        case ($urandom_range(3))
            0:       w[15:12] = 4'h8;        // LDD/STD
            1:       w[15:12] = 4'hD;        // RCALL
            2:       w[15:11] = 5'b10110;    // IN
            default: w[15:9]  = 7'b1001000;  // LD/LDS
        endcase
    end else if (pick < 27) begin
        w = 16'h0000;
    end else if (pick < 42) begin
        w[15:12] = 4'hE;
    end else if (pick < 62) begin
        w[15:10] = REG_OPS[$urandom_range(9)];
    end else if (pick < 74) begin
        w[15:12] = 4'h3 + 4'($urandom_range(4));   // CPI..ANDI
    end else if (pick < 86) begin
        w[15:9] = 7'b1001010;
        w[3:0]  = SINGLE_OPS[$urandom_range(7)];
    end else if (pick < 90) begin
        w[15:12] = 4'hC;
    end else begin
        w[15:11] = 5'b11110;
    end
    return w;
endfunction

`endif

/* test/avr_core_tb.sv */
`default_nettype none

module avr_core_tb
    import avr_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int RUN_LEN      = 2000;

    logic     clock = 1'b0;
    logic     rst_n_i;
    insn_t    ir_i;
    pc_t      pc_o;
    logic     io_we_o;
    io_addr_t io_addr_o;
    byte_t    io_data_o;

    int       errors       = 0;
    int       insn_count   = 0;   // Instructions issued so far
    int       outs_checked = 0;
    insn_t    last_insn    = 16'h0000;

    `include "avr_model.svh"

    avr_core DUT (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .ir_i      (ir_i),
        .pc_o      (pc_o),
        .io_we_o   (io_we_o),
        .io_addr_o (io_addr_o),
        .io_data_o (io_data_o)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // ----------------------------------------------------------
    // Checks against the model
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("[FAIL] %s after insn %0d (ir 0x%h): expected 0x%0h, actual 0x%0h",
                     name, insn_count, last_insn, exp, act);
        end
    endtask

    task automatic check_outputs();
        check_value("pc_o", 32'(m_pc), 32'(pc_o));
        check_value("io_we_o", 32'(m_out_we), 32'(io_we_o));
        if (m_out_we) begin   // Address and data only valid with the strobe
            check_value("io_addr_o", 32'(m_out_addr), 32'(io_addr_o));
            check_value("io_data_o", 32'(m_out_data), 32'(io_data_o));
            outs_checked++;
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus, one instruction per falling edge
    // ----------------------------------------------------------
    initial begin
        insn_t w;
        void'($urandom(32'hb9f4));
        rst_n_i = 1'b0;
        ir_i    = 16'h0000;
        model_reset();
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n_i = 1'b1;
        for (int n = 0; n < RUN_LEN; n++) begin
            check_outputs();          // Effect of the previous instruction
            w          = random_insn();
            ir_i       = w;
            last_insn  = w;
            insn_count = n + 1;
            model_step(w);
            @(negedge clock);
        end
        check_outputs();
        $display("%0d errors in %0d instructions, %0d OUT writes checked",
                 errors, RUN_LEN, outs_checked);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + RUN_LEN + 50) * CLK_PERIOD);
        $display("Timeout after %0d cycles, run did not complete",
                 RESET_CYCLES + RUN_LEN + 50);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
common/avr_pkg.sv
verilog/avr_regfile.sv
decode/avr_decode.sv
alu/avr_alu.sv
verilog/avr_core.sv
test/avr_core_tb.sv

/* Makefile */
TOP = avr_core_tb

all: run

build:
	verilator --binary --assert -Wno-fatal -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --assert --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
